/* rtl/lsu_params.svh */
// Width and depth macros for the store path of the load/store unit
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data path and byte address widths
`define LSU_DATA_WIDTH    32
`define LSU_ADDR_WIDTH    32
`define LSU_BE_WIDTH      4

// Store queue depth and the index width that covers it
`define LSU_SQ_DEPTH      8
`define LSU_SQ_IDX_WIDTH  3

// Tag width of the reorder buffer
`define LSU_ROB_IDX_WIDTH 5

`endif

/* rtl/lsu_pkg.sv */
// Store opcodes, queue entry states, store data union and store path structs
`include "lsu_params.svh"

package lsu_pkg;

    // Store size encodings as issued by the reservation station
    typedef enum logic [1:0] {
        ST_OP_SB = 2'b00,
        ST_OP_SH = 2'b01,
        ST_OP_SW = 2'b10
    } st_op_e;

    // Lifetime of one store queue slot
    typedef enum logic [1:0] {
        SQ_EMPTY       = 2'b00,
        SQ_SPECULATIVE = 2'b01,
        SQ_RETIRABLE   = 2'b10,
        SQ_LAUNCHED    = 2'b11
    } sq_state_e;

    // The same store data seen as a whole word or as individual byte lanes
    typedef union packed {
        logic [`LSU_DATA_WIDTH-1:0]    word;
        logic [`LSU_BE_WIDTH-1:0][7:0] bytes;
    } st_data_u;

    typedef struct packed {
        st_op_e                        op;
        logic [`LSU_ROB_IDX_WIDTH-1:0] tag;
        logic [`LSU_ADDR_WIDTH-1:0]    addr;
        st_data_u                      data;
    } sq_store_t;

    // A store on its way to the launch stage, with the slot it came from
    typedef struct packed {
        sq_store_t                    store;
        logic [`LSU_SQ_IDX_WIDTH-1:0] idx;
    } sq_launch_t;

    typedef struct packed {
        logic [`LSU_ADDR_WIDTH-1:0] addr;
        logic [`LSU_BE_WIDTH-1:0]   be;
        logic [`LSU_DATA_WIDTH-1:0] wdata;
    } mem_req_t;

endpackage

/* rtl/lsu_sq_entry.sv */
// Single store queue slot with its state FSM and the store it holds
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_sq_entry (
    input  logic                          clk,
    input  logic                          i_rst_n,

    input  logic                          i_flush,

    // Allocation from the issue side
    input  logic                          i_alloc_en,
    input  lsu_pkg::sq_store_t            i_alloc,

    // Slot picked by the queue for launch
    input  logic                          i_launch_en,

    // ROB retirement of a store tag
    input  logic                          i_rob_retire_en,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0] i_rob_retire_tag,

    // Outcome of the memory write for this slot
    input  logic                          i_update_en,
    input  logic                          i_update_retry,

    output lsu_pkg::sq_state_e            o_state,
    output lsu_pkg::sq_store_t            o_store,
    output logic                          o_rob_retire_ack
);

    lsu_pkg::sq_state_e state_q;
    lsu_pkg::sq_state_e state_d;
    lsu_pkg::sq_store_t store_q;
    logic               tag_match;

    // The tag only means something while the store is still speculative
    assign tag_match = (state_q == lsu_pkg::SQ_SPECULATIVE) &&
                       (store_q.tag == i_rob_retire_tag);

    // A flush in the same cycle discards the store, so no ack is given
    assign o_rob_retire_ack = i_rob_retire_en && !i_flush && tag_match;

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::SQ_EMPTY: begin
                // Stores arriving with a flush are on the wrong path
                if (i_alloc_en && !i_flush) begin
                    state_d = lsu_pkg::SQ_SPECULATIVE;
                end
            end
            lsu_pkg::SQ_SPECULATIVE: begin
                if (i_flush) begin
                    state_d = lsu_pkg::SQ_EMPTY;
                end else if (o_rob_retire_ack) begin
                    state_d = lsu_pkg::SQ_RETIRABLE;
                end
            end
            lsu_pkg::SQ_RETIRABLE: begin
                if (i_launch_en) begin
                    state_d = lsu_pkg::SQ_LAUNCHED;
                end
            end
            lsu_pkg::SQ_LAUNCHED: begin
                // A retried write waits in the queue to be launched again
                if (i_update_en) begin
                    state_d = i_update_retry ? lsu_pkg::SQ_RETIRABLE : lsu_pkg::SQ_EMPTY;
                end
            end
            default: begin
                state_d = lsu_pkg::SQ_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= lsu_pkg::SQ_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            store_q <= i_alloc;
        end
    end

    assign o_state = state_q;
    assign o_store = store_q;

endmodule

/* rtl/lsu_sq.sv */
// Store queue with slot array, allocate and launch pickers and registered outputs
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_sq (
    input  logic                          clk,
    input  logic                          i_rst_n,

    input  logic                          i_flush,
    output logic                          o_full,
    output logic                          o_nonspeculative_pending,

    input  logic                          i_alloc_en,
    input  lsu_pkg::sq_store_t            i_alloc,

    input  logic                          i_rob_retire_en,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0] i_rob_retire_tag,
    output logic                          o_rob_retire_ack,

    // Retired stores toward the launch stage
    input  logic                          i_launch_ready,
    output logic                          o_launch_valid,
    output lsu_pkg::sq_launch_t           o_launch,

    // Write outcome reported back by the launch stage
    input  logic                          i_update_en,
    input  logic [`LSU_SQ_IDX_WIDTH-1:0]  i_update_idx,
    input  logic                          i_update_retry
);

    lsu_pkg::sq_state_e           entry_state [`LSU_SQ_DEPTH];
    lsu_pkg::sq_store_t           entry_store [`LSU_SQ_DEPTH];
    logic [`LSU_SQ_DEPTH-1:0]     entry_empty;
    logic [`LSU_SQ_DEPTH-1:0]     entry_retirable;
    logic [`LSU_SQ_DEPTH-1:0]     entry_launched;
    logic [`LSU_SQ_DEPTH-1:0]     entry_ack;
    logic [`LSU_SQ_DEPTH-1:0]     alloc_select;
    logic [`LSU_SQ_DEPTH-1:0]     launch_picked;
    logic [`LSU_SQ_DEPTH-1:0]     launch_select;
    logic [`LSU_SQ_DEPTH-1:0]     update_select;
    logic [`LSU_SQ_IDX_WIDTH-1:0] launch_idx;
    logic                         launch_take;

    // Isolate the lowest set bit
    function automatic logic [`LSU_SQ_DEPTH-1:0] pick_lowest(
        input logic [`LSU_SQ_DEPTH-1:0] req
    );
        return req & (~req + 1'b1);
    endfunction

    function automatic logic [`LSU_SQ_IDX_WIDTH-1:0] onehot_to_idx(
        input logic [`LSU_SQ_DEPTH-1:0] onehot
    );
        logic [`LSU_SQ_IDX_WIDTH-1:0] idx;
        idx = '0;
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            if (onehot[i]) begin
                idx = idx | `LSU_SQ_IDX_WIDTH'(i);
            end
        end
        return idx;
    endfunction

    for (genvar g = 0; g < `LSU_SQ_DEPTH; g++) begin : gen_entry
        lsu_sq_entry u_entry (
            .clk              (clk),
            .i_rst_n          (i_rst_n),
            .i_flush          (i_flush),
            .i_alloc_en       (alloc_select[g]),
            .i_alloc          (i_alloc),
            .i_launch_en      (launch_select[g]),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .i_update_en      (update_select[g]),
            .i_update_retry   (i_update_retry),
            .o_state          (entry_state[g]),
            .o_store          (entry_store[g]),
            .o_rob_retire_ack (entry_ack[g])
        );

        assign entry_empty[g]     = (entry_state[g] == lsu_pkg::SQ_EMPTY);
        assign entry_retirable[g] = (entry_state[g] == lsu_pkg::SQ_RETIRABLE);
        assign entry_launched[g]  = (entry_state[g] == lsu_pkg::SQ_LAUNCHED);
    end

    assign alloc_select  = {`LSU_SQ_DEPTH{i_alloc_en}} & pick_lowest(entry_empty);
    assign update_select = {`LSU_SQ_DEPTH{i_update_en}} & (`LSU_SQ_DEPTH'(1) << i_update_idx);

    // Full once the last empty slot is taken by the allocation in flight
    assign o_full = ((entry_empty & ~alloc_select) == '0);

    // Retired stores still owe a write to memory
    assign o_nonspeculative_pending = |(entry_retirable | entry_launched);

    // A held output register stops all launches until the launch stage takes it
    assign launch_take   = !o_launch_valid || i_launch_ready;
    assign launch_picked = pick_lowest(entry_retirable);
    assign launch_select = {`LSU_SQ_DEPTH{launch_take}} & launch_picked;
    assign launch_idx    = onehot_to_idx(launch_picked);

    // The output register survives a flush since its store is already retired
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_launch_valid   <= 1'b0;
            o_rob_retire_ack <= 1'b0;
        end else begin
            if (launch_take) begin
                o_launch_valid <= |launch_picked;
            end
            o_rob_retire_ack <= |entry_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (launch_take && |launch_picked) begin
            o_launch.store <= entry_store[launch_idx];
            o_launch.idx   <= launch_idx;
        end
    end

endmodule

/* rtl/lsu_st_launch.sv */
// Launch stage that aligns a retired store and offers it to the data memory port
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_st_launch (
    input  logic                         clk,
    input  logic                         i_rst_n,

    // Store from the queue
    input  logic                         i_launch_valid,
    output logic                         o_launch_ready,
    input  lsu_pkg::sq_launch_t          i_launch,

    // Data memory write port
    output logic                         o_mem_valid,
    input  logic                         i_mem_ready,
    input  logic                         i_mem_retry,
    output lsu_pkg::mem_req_t            o_mem_req,

    // Write outcome back to the queue
    output logic                         o_update_en,
    output logic [`LSU_SQ_IDX_WIDTH-1:0] o_update_idx,
    output logic                         o_update_retry
);

    lsu_pkg::st_data_u            data_in;
    lsu_pkg::st_data_u            data_aligned;
    lsu_pkg::mem_req_t            req_d;
    logic [1:0]                   lane;
    logic [`LSU_SQ_IDX_WIDTH-1:0] idx_q;
    logic                         mem_accept;
    logic                         load_en;

    assign mem_accept     = o_mem_valid && i_mem_ready;
    assign o_launch_ready = !o_mem_valid || i_mem_ready;
    assign load_en        = i_launch_valid && o_launch_ready;

    assign data_in = i_launch.store.data;
    assign lane    = i_launch.store.addr[1:0];

    // Sub-word stores go to the byte lanes picked by the low address bits
    always_comb begin
        data_aligned.word = '0;
        req_d.be          = '0;
        case (i_launch.store.op)
            lsu_pkg::ST_OP_SB: begin
                req_d.be[lane]           = 1'b1;
                data_aligned.bytes[lane] = data_in.bytes[0];
            end
            lsu_pkg::ST_OP_SH: begin
                req_d.be = `LSU_BE_WIDTH'(2'b11) << {lane[1], 1'b0};
                data_aligned.bytes[{lane[1], 1'b0}] = data_in.bytes[0];
                data_aligned.bytes[{lane[1], 1'b1}] = data_in.bytes[1];
            end
            default: begin
                req_d.be          = '1;
                data_aligned.word = data_in.word;
            end
        endcase
        req_d.addr  = {i_launch.store.addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
        req_d.wdata = data_aligned.word;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_valid <= 1'b0;
        end else if (load_en) begin
            o_mem_valid <= 1'b1;
        end else if (mem_accept) begin
            o_mem_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            o_mem_req <= req_d;
            idx_q     <= i_launch.idx;
        end
    end

    // Every handshake closes out the held slot, retried or not
    assign o_update_en    = mem_accept;
    assign o_update_idx   = idx_q;
    assign o_update_retry = i_mem_retry;

endmodule

/* rtl/lsu_store_path.sv */
// Store path top level joining the store queue and the launch stage
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_store_path (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    input  logic                          i_alloc_en,
    input  lsu_pkg::sq_store_t            i_alloc,
    input  logic                          i_rob_retire_en,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0] i_rob_retire_tag,
    input  logic                          i_mem_ready,
    input  logic                          i_mem_retry,
    output logic                          o_full,
    output logic                          o_nonspeculative_pending,
    output logic                          o_rob_retire_ack,
    output logic                          o_mem_valid,
    output lsu_pkg::mem_req_t             o_mem_req
);

    logic                         launch_valid;
    logic                         launch_ready;
    lsu_pkg::sq_launch_t          launch;
    logic                         update_en;
    logic [`LSU_SQ_IDX_WIDTH-1:0] update_idx;
    logic                         update_retry;

    lsu_sq u_sq (
        .clk                      (clk),
        .i_rst_n                  (i_rst_n),
        .i_flush                  (i_flush),
        .o_full                   (o_full),
        .o_nonspeculative_pending (o_nonspeculative_pending),
        .i_alloc_en               (i_alloc_en),
        .i_alloc                  (i_alloc),
        .i_rob_retire_en          (i_rob_retire_en),
        .i_rob_retire_tag         (i_rob_retire_tag),
        .o_rob_retire_ack         (o_rob_retire_ack),
        .i_launch_ready           (launch_ready),
        .o_launch_valid           (launch_valid),
        .o_launch                 (launch),
        .i_update_en              (update_en),
        .i_update_idx             (update_idx),
        .i_update_retry           (update_retry)
    );

    lsu_st_launch u_st_launch (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_launch_valid (launch_valid),
        .o_launch_ready (launch_ready),
        .i_launch       (launch),
        .o_mem_valid    (o_mem_valid),
        .i_mem_ready    (i_mem_ready),
        .i_mem_retry    (i_mem_retry),
        .o_mem_req      (o_mem_req),
        .o_update_en    (update_en),
        .o_update_idx   (update_idx),
        .o_update_retry (update_retry)
    );

endmodule

/* test/tb_lsu_store_path.sv */
// Random-stimulus testbench for the store path with a scoreboard model of retired stores
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_store_path;

    logic                          clk;
    logic                          i_rst_n;
    logic                          i_flush;
    logic                          i_alloc_en;
    lsu_pkg::sq_store_t            i_alloc;
    logic                          i_rob_retire_en;
    logic [`LSU_ROB_IDX_WIDTH-1:0] i_rob_retire_tag;
    logic                          i_mem_ready;
    logic                          i_mem_retry;
    logic                          o_full;
    logic                          o_nonspeculative_pending;
    logic                          o_rob_retire_ack;
    logic                          o_mem_valid;
    lsu_pkg::mem_req_t             o_mem_req;

    // Speculative stores in allocation order and retired writes still owed to memory
    lsu_pkg::sq_store_t            spec_q[$];
    lsu_pkg::mem_req_t             pend_q[$];
    lsu_pkg::mem_req_t             stall_req;
    logic [`LSU_ROB_IDX_WIDTH-1:0] next_tag;
    logic [`LSU_ROB_IDX_WIDTH-1:0] flushed_tag;
    bit                            have_flushed;
    bit                            exp_ack;
    bit                            stalled;
    bit                            full_seen;
    bit                            last_full;
    int                            errors;
    int                            checks;

    lsu_store_path DUT (
        .clk                      (clk),
        .i_rst_n                  (i_rst_n),
        .i_flush                  (i_flush),
        .i_alloc_en               (i_alloc_en),
        .i_alloc                  (i_alloc),
        .i_rob_retire_en          (i_rob_retire_en),
        .i_rob_retire_tag         (i_rob_retire_tag),
        .i_mem_ready              (i_mem_ready),
        .i_mem_retry              (i_mem_retry),
        .o_full                   (o_full),
        .o_nonspeculative_pending (o_nonspeculative_pending),
        .o_rob_retire_ack         (o_rob_retire_ack),
        .o_mem_valid              (o_mem_valid),
        .o_mem_req                (o_mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Word-aligned write with the data shifted into the lanes picked by the address
    function automatic lsu_pkg::mem_req_t expected_req(input lsu_pkg::sq_store_t s);
        lsu_pkg::mem_req_t r;
        r.addr = s.addr & ~(`LSU_ADDR_WIDTH'(3));
        case (s.op)
            lsu_pkg::ST_OP_SB: begin
                r.be    = 4'h1 << s.addr[1:0];
                r.wdata = (s.data.word & 32'h0000_00ff) << (8 * s.addr[1:0]);
            end
            lsu_pkg::ST_OP_SH: begin
                r.be    = 4'h3 << (2 * s.addr[1]);
                r.wdata = (s.data.word & 32'h0000_ffff) << (16 * s.addr[1]);
            end
            default: begin
                r.be    = 4'hf;
                r.wdata = s.data.word;
            end
        endcase
        return r;
    endfunction

    function automatic int find_pending(input lsu_pkg::mem_req_t req);
        for (int i = 0; i < pend_q.size(); i++) begin
            if (pend_q[i] === req) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Compare outputs with the model, then apply the events of the coming edge to it
    task automatic check_and_model();
        int idx;
        check_value("o_rob_retire_ack", o_rob_retire_ack, exp_ack);
        check_value("o_nonspeculative_pending", o_nonspeculative_pending, pend_q.size() != 0);
        check_value("o_full", o_full,
                    (spec_q.size() + pend_q.size() + i_alloc_en) >= `LSU_SQ_DEPTH);
        if (o_full) begin
            full_seen = 1'b1;
        end
        last_full = o_full;
        if (stalled) begin
            check_value("o_mem_valid", o_mem_valid, 1'b1);
            check_value("o_mem_req", o_mem_req, stall_req);
        end
        stalled   = o_mem_valid && !i_mem_ready;
        stall_req = o_mem_req;
        if (o_mem_valid && i_mem_ready) begin
            idx = find_pending(o_mem_req);
            if (idx < 0) begin
                errors++;
                $display("Memory request %h matches no retired store waiting for its write",
                         o_mem_req);
            end else if (!i_mem_retry) begin
                pend_q.delete(idx);
            end
        end
        exp_ack = 1'b0;
        if (i_rob_retire_en && !i_flush) begin
            for (int i = 0; i < spec_q.size(); i++) begin
                if (spec_q[i].tag == i_rob_retire_tag) begin
                    exp_ack = 1'b1;
                    pend_q.push_back(expected_req(spec_q[i]));
                    spec_q.delete(i);
                    break;
                end
            end
        end
        if (i_flush) begin
            if (spec_q.size() != 0) begin
                have_flushed = 1'b1;
                flushed_tag  = spec_q[$].tag;
            end
            spec_q.delete();
        end
        if (i_alloc_en && !i_flush) begin
            spec_q.push_back(i_alloc);
        end
    endtask

    task automatic drive_inputs(input int alloc_pct, input int retire_pct,
                                input int flush_pct, input int ready_pct);
        lsu_pkg::sq_store_t s;
        i_flush         = ($urandom_range(99) < flush_pct);
        i_alloc_en      = 1'b0;
        i_rob_retire_en = 1'b0;
        if (!i_flush && !last_full && ($urandom_range(99) < alloc_pct)) begin
            s.op       = lsu_pkg::st_op_e'($urandom_range(2));
            s.tag      = next_tag;
            s.addr     = $urandom();
            s.data.word = $urandom();
            next_tag   = next_tag + 1'b1;
            i_alloc    = s;
            i_alloc_en = 1'b1;
        end
        if ($urandom_range(99) < retire_pct) begin
            // Now and then the ROB names a store that was already flushed
            if (spec_q.size() != 0 && $urandom_range(9) != 0) begin
                i_rob_retire_en  = 1'b1;
                i_rob_retire_tag = spec_q[0].tag;
            end else if (have_flushed) begin
                i_rob_retire_en  = 1'b1;
                i_rob_retire_tag = flushed_tag;
            end
        end
        i_mem_ready = ($urandom_range(99) < ready_pct);
        i_mem_retry = ($urandom_range(3) == 0);
    endtask

    task automatic run_cycles(input int n, input int alloc_pct, input int retire_pct,
                              input int flush_pct, input int ready_pct);
        repeat (n) begin
            @(posedge clk);
            #1;
            drive_inputs(alloc_pct, retire_pct, flush_pct, ready_pct);
            @(negedge clk);
            check_and_model();
        end
    endtask

    initial begin
        int waited;
        i_rst_n          = 1'b0;
        i_flush          = 1'b0;
        i_alloc_en       = 1'b0;
        i_alloc          = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        i_mem_ready      = 1'b0;
        i_mem_retry      = 1'b0;
        next_tag         = '0;
        flushed_tag      = '0;
        have_flushed     = 1'b0;
        exp_ack          = 1'b0;
        stalled          = 1'b0;
        full_seen        = 1'b0;
        last_full        = 1'b0;
        errors           = 0;
        checks           = 0;
        void'($urandom(52069));

        repeat (10) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge clk);
        check_value("o_mem_valid", o_mem_valid, 1'b0);
        check_and_model();

        // Memory held off so the queue must fill up
        run_cycles(40, 100, 30, 0, 0);
        if (!full_seen) begin
            errors++;
            $display("The queue never reported full while the memory was stalled");
        end

        run_cycles(3000, 40, 30, 2, 60);

        // Retire everything left and let every write complete
        waited = 0;
        while ((spec_q.size() != 0 || pend_q.size() != 0) && waited < 500) begin
            run_cycles(1, 0, 100, 0, 100);
            waited++;
        end
        if (spec_q.size() != 0 || pend_q.size() != 0) begin
            errors++;
            $display("Timed out waiting for the retired stores to be written to memory");
        end
        run_cycles(3, 0, 0, 0, 100);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_sq_entry.sv
rtl/lsu_sq.sv
rtl/lsu_st_launch.sv
rtl/lsu_store_path.sv
test/tb_lsu_store_path.sv

/* Bender.yml */
package:
  name: lsu_store_path

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_sq_entry.sv
      - rtl/lsu_sq.sv
      - rtl/lsu_st_launch.sv
      - rtl/lsu_store_path.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_lsu_store_path.sv
